// ==== verilog/motor_pwm_pkg.sv ====
package motor_pwm_pkg;

    // PWM timing
    localparam int duty_width        = 12;
    localparam int pwm_period        = 250;   // Clocks per carrier half-period
    localparam int max_on_cycles     = 240;   // Clamp for every duty value
    localparam int counter_width     = $clog2(pwm_period);
    localparam int initial_direction = 0;     // 0 up, 1 down

    // APB register byte offsets
    localparam logic [7:0] addr_duty_u = 8'h00;
    localparam logic [7:0] addr_duty_v = 8'h04;
    localparam logic [7:0] addr_duty_w = 8'h08;
    localparam logic [7:0] addr_commit = 8'h0C;
    localparam logic [7:0] addr_ctrl   = 8'h10;
    localparam logic [7:0] addr_status = 8'h14;

    typedef struct packed {
        logic [duty_width-1:0] u;
        logic [duty_width-1:0] v;
        logic [duty_width-1:0] w;
    } duty_set_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Bit 2 is phase u, bit 1 is v, bit 0 is w
    typedef struct packed {
        logic [2:0] pwm;
        logic [2:0] reset_n;
    } phase_out_t;

endpackage

// ==== verilog/pwm_apb_regs.sv ====
`timescale 1ns/1ps

module pwm_apb_regs
    import motor_pwm_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    input  logic      fault_in,
    output logic      enable,
    output logic      pwm_valid,
    output duty_set_t pwm_duty,
    output logic      fault
);

    logic        access;
    logic        wr_access;
    logic        addr_mapped;
    logic        status_clear;
    logic        fault_meta;
    logic        fault_sync;
    logic [31:0] read_data;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr_access = access & apb_req.pwrite;

    // Address decode and read mux
    always_comb begin
        addr_mapped = 1'b1;
        read_data   = '0;
        case (apb_req.paddr)
            addr_duty_u: begin
                read_data = 32'(pwm_duty.u);
            end
            addr_duty_v: begin
                read_data = 32'(pwm_duty.v);
            end
            addr_duty_w: begin
                read_data = 32'(pwm_duty.w);
            end
            addr_commit: begin
                read_data = '0;   // Write-only
            end
            addr_ctrl: begin
                read_data = {31'b0, enable};
            end
            addr_status: begin
                read_data = {31'b0, fault};
            end
            default: begin
                addr_mapped = 1'b0;
            end
        endcase
    end

    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? read_data : '0;
    assign apb_rsp.pready  = 1'b1;    // No wait states
    assign apb_rsp.pslverr = access & ~addr_mapped;

    assign status_clear = wr_access && (apb_req.paddr == addr_status) && apb_req.pwdata[0];

    // Duty, control and commit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_duty  <= '0;
            enable    <= 1'b0;
            pwm_valid <= 1'b0;
        end else begin
            pwm_valid <= wr_access && (apb_req.paddr == addr_commit);
            if (wr_access) begin
                case (apb_req.paddr)
                    addr_duty_u: begin
                        pwm_duty.u <= apb_req.pwdata[duty_width-1:0];
                    end
                    addr_duty_v: begin
                        pwm_duty.v <= apb_req.pwdata[duty_width-1:0];
                    end
                    addr_duty_w: begin
                        pwm_duty.w <= apb_req.pwdata[duty_width-1:0];
                    end
                    addr_ctrl: begin
                        enable <= apb_req.pwdata[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Fault input synchronizer and sticky latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_meta <= 1'b0;
            fault_sync <= 1'b0;
            fault      <= 1'b0;
        end else begin
            fault_meta <= fault_in;
            fault_sync <= fault_meta;
            fault      <= fault_sync | (fault & ~status_clear);  // Live fault wins over clear
        end
    end

endmodule

// ==== verilog/pwm_half_period_timer.sv ====
`timescale 1ns/1ps

module pwm_half_period_timer
    import motor_pwm_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic trigger
);

    logic [counter_width-1:0] count;
    logic                     wrap;

    assign wrap = (count == counter_width'(pwm_period - 1));

    // One trigger per half-period, count restarts when disabled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            trigger <= 1'b0;
        end else if (!enable) begin
            count   <= '0;
            trigger <= 1'b0;
        end else begin
            count   <= wrap ? '0 : count + 1'b1;
            trigger <= wrap;
        end
    end

endmodule

// ==== verilog/pwm_three_phase_driver.sv ====
`timescale 1ns/1ps

module pwm_three_phase_driver
    import motor_pwm_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       trigger,
    input  logic       fault,
    input  logic       pwm_valid,
    input  duty_set_t  pwm_duty,
    output phase_out_t phase_out
);

    logic                          dir;       // 0 up, 1 down
    logic [counter_width-1:0]      carrier;
    logic                          drive;
    logic                          update;
    logic [2:0][counter_width-1:0] compare;
    logic [2:0][counter_width-1:0] compare_pending;
    logic [2:0]                    pwm_ff;
    logic                          drive_ff;

    function automatic logic [counter_width-1:0] clamp_duty(
        input logic [duty_width-1:0] duty
    );
        if (duty < duty_width'(max_on_cycles)) begin
            return counter_width'(duty);
        end
        return counter_width'(max_on_cycles);
    endfunction

    // Update buffer, index follows phase_out bit order
    always_ff @(posedge clk) begin
        if (pwm_valid) begin
            compare_pending[2] <= clamp_duty(pwm_duty.u);
            compare_pending[1] <= clamp_duty(pwm_duty.v);
            compare_pending[0] <= clamp_duty(pwm_duty.w);
        end
    end

    // Carrier, direction and active compare set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dir     <= 1'(initial_direction);
            carrier <= '0;
            drive   <= 1'b0;
            compare <= '0;
            update  <= 1'b0;
        end else begin
            update <= (pwm_valid | (update & ~trigger)) & ~fault;
            if (trigger) begin
                dir     <= ~dir;
                carrier <= dir ? '0 : counter_width'(pwm_period - 1);
            end else if (!dir) begin
                // Hold at the top if the trigger is late
                if (carrier < counter_width'(pwm_period - 1)) begin
                    carrier <= carrier + 1'b1;
                end
            end else if (carrier != '0) begin
                carrier <= carrier - 1'b1;
            end
            if (fault) begin
                drive <= 1'b0;
            end else if (trigger && update) begin
                drive   <= 1'b1;
                compare <= compare_pending;   // New set only at a turn-around
            end
        end
    end

    // Two register stages to the gate driver
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_ff    <= '0;
            drive_ff  <= 1'b0;
            phase_out <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                pwm_ff[i] <= drive & ~fault & (carrier < compare[i]);
            end
            drive_ff          <= drive & ~fault;   // Fault stops driving at once
            phase_out.pwm     <= pwm_ff;
            phase_out.reset_n <= {3{drive_ff}};   // Released only while driving
        end
    end

endmodule

// ==== verilog/motor_pwm_top.sv ====
`timescale 1ns/1ps

module motor_pwm_top
    import motor_pwm_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  logic       fault_in,
    output phase_out_t phase_out
);

    logic      enable;
    logic      trigger;
    logic      pwm_valid;
    duty_set_t pwm_duty;
    logic      fault;

    pwm_apb_regs regs0 (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .fault_in  (fault_in),
        .enable    (enable),
        .pwm_valid (pwm_valid),
        .pwm_duty  (pwm_duty),
        .fault     (fault)
    );

    // Sets the switching frequency
    pwm_half_period_timer timer0 (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .trigger (trigger)
    );

    pwm_three_phase_driver driver0 (
        .clk       (clk),
        .reset     (reset),
        .trigger   (trigger),
        .fault     (fault),
        .pwm_valid (pwm_valid),
        .pwm_duty  (pwm_duty),
        .phase_out (phase_out)
    );

endmodule

// ==== verif/tb_motor_pwm.sv ====
`timescale 1ns/1ps

module tb_motor_pwm
    import motor_pwm_pkg::*;
();

    localparam int apb_timeout     = 16;
    localparam int measure_timeout = 12 * pwm_period;
    localparam int fault_timeout   = 5;
    localparam int settle_cycles   = pwm_period + 8;   // New set applied by then

    logic       clk;
    logic       reset;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       fault_in;
    phase_out_t phase_out;

    integer     seed;
    int         value_errors;
    int         timeout_errors;
    int         n;
    duty_set_t  duty;
    duty_set_t  old_duty;
    phase_out_t full_mask;
    phase_out_t reset_n_mask;
    logic [7:0] addr;

    motor_pwm_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .fault_in  (fault_in),
        .phase_out (phase_out)
    );

    always #10 clk = ~clk;

    // Model of one phase, high time is twice the clamped duty
    function automatic logic [duty_width-1:0] model_width(input logic [duty_width-1:0] d);
        if (d > max_on_cycles) begin
            return duty_width'(2 * max_on_cycles);
        end
        return duty_width'(2 * d);
    endfunction

    function automatic duty_set_t expected_widths(input duty_set_t d);
        duty_set_t e;
        e.u = model_width(d.u);
        e.v = model_width(d.v);
        e.w = model_width(d.w);
        return e;
    endfunction

    function automatic apb_rsp_t make_rsp(input logic [31:0] prdata, input logic pslverr);
        apb_rsp_t r;
        r.prdata  = prdata;
        r.pready  = 1'b1;
        r.pslverr = pslverr;
        return r;
    endfunction

    task automatic check_rsp(input string name, input apb_rsp_t expected, input apb_rsp_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_duty(input string name, input duty_set_t expected,
                              input duty_set_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_phase(input string name, input phase_out_t expected,
                               input phase_out_t actual, input phase_out_t mask);
        if ((actual & mask) !== (expected & mask)) begin
            value_errors++;
            $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] a, input logic [31:0] data,
                                output apb_rsp_t rsp);
        int waits;
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;   // Setup cycle
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = a;
        apb_req.pwdata  = data;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waits < apb_timeout) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready) begin
            timeout_errors++;
            $display("APB access to offset %h never saw pready", a);
        end
        rsp = apb_rsp;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] data, input logic exp_err);
        apb_rsp_t r;
        apb_transfer(1'b1, a, data, r);
        r.prdata = '0;
        check_rsp($sformatf("apb write rsp at %h", a), make_rsp('0, exp_err), r);
    endtask

    task automatic apb_read_check(input logic [7:0] a, input logic [31:0] exp_data,
                                  input logic exp_err);
        apb_rsp_t r;
        apb_transfer(1'b0, a, '0, r);
        check_rsp($sformatf("apb read rsp at %h", a), make_rsp(exp_data, exp_err), r);
    endtask

    task automatic write_duties(input duty_set_t d);
        apb_write(addr_duty_u, 32'(d.u), 1'b0);
        apb_write(addr_duty_v, 32'(d.v), 1'b0);
        apb_write(addr_duty_w, 32'(d.w), 1'b0);
    endtask

    task automatic random_duty(output duty_set_t d, input int low, input int span);
        d.u = duty_width'(low + {$random(seed)} % span);
        d.v = duty_width'(low + {$random(seed)} % span);
        d.w = duty_width'(low + {$random(seed)} % span);
    endtask

    // Skips two rising edges per phase and times the third pulse
    task automatic measure_widths(input duty_set_t expected, output duty_set_t measured,
                                  output logic all_done);
        logic [duty_width-1:0] exp_w[3];
        int                    rises[3];
        int                    width[3];
        logic                  done[3];
        logic                  prev[3];
        logic                  cur;
        logic                  any_zero;
        int                    cycles;
        exp_w[2] = expected.u;
        exp_w[1] = expected.v;
        exp_w[0] = expected.w;
        any_zero = 1'b0;
        for (int i = 0; i < 3; i++) begin
            rises[i] = 0;
            width[i] = 0;
            prev[i]  = 1'b1;   // A pulse already running is not a rise
            done[i]  = (exp_w[i] == 0);
            any_zero = any_zero | done[i];
        end
        cycles = 0;
        while ((!(done[0] && done[1] && done[2]) ||
                (any_zero && cycles < settle_cycles + 3 * pwm_period)) &&
               cycles < measure_timeout) begin
            @(negedge clk);
            cycles++;
            for (int i = 0; i < 3; i++) begin
                cur = phase_out.pwm[i];
                if (exp_w[i] == 0) begin
                    if (cur && cycles > settle_cycles) width[i]++;
                end else if (!done[i]) begin
                    if (cur && !prev[i]) rises[i]++;
                    if (rises[i] == 3) begin
                        if (cur) width[i]++;
                        else done[i] = 1'b1;
                    end
                end
                prev[i] = cur;
            end
            if (rises[0] + rises[1] + rises[2] > 0) begin
                check_phase("phase_out.reset_n", reset_n_mask, phase_out, reset_n_mask);
            end
        end
        all_done = done[0] && done[1] && done[2];
        if (!all_done) begin
            timeout_errors++;
            $display("No complete third pulse on every phase within %0d cycles", measure_timeout);
        end
        measured.u = duty_width'(width[2]);
        measured.v = duty_width'(width[1]);
        measured.w = duty_width'(width[0]);
    endtask

    task automatic run_check(input string name, input duty_set_t d);
        duty_set_t w;
        logic      fine;
        measure_widths(expected_widths(d), w, fine);
        if (fine) check_duty(name, expected_widths(d), w);
    endtask

    initial begin
        #4_000_000;
        $display("Run stopped at its time limit, errors %0d value, %0d timeout",
                 value_errors, timeout_errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed           = 49;
        value_errors   = 0;
        timeout_errors = 0;
        clk            = 1'b0;
        reset          = 1'b1;
        apb_req        = '0;
        fault_in       = 1'b0;
        full_mask      = '1;
        reset_n_mask   = '0;
        reset_n_mask.reset_n = 3'b111;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // Register access
        @(negedge clk);
        check_phase("phase_out after reset", '0, phase_out, full_mask);
        for (n = 0; n < 9; n++) begin
            random_duty(duty, 0, 1 << duty_width);
            addr = 8'(4 * (n % 3));
            apb_write(addr, 32'(duty.u), 1'b0);
            apb_read_check(addr, 32'(duty.u), 1'b0);
        end
        apb_write(8'h18, $random(seed), 1'b1);
        apb_read_check(8'h1C, '0, 1'b1);
        apb_read_check(8'h02, '0, 1'b1);

        // Duty to pulse width
        for (n = 0; n < 20; n++) begin
            random_duty(duty, 0, 300);
            if (n % 5 == 4) duty.w = '0;
            write_duties(duty);
            apb_write(addr_commit, 32'h1, 1'b0);
            apb_write(addr_ctrl, 32'h1, 1'b0);
            run_check($sformatf("pulse widths of set %0d", n), duty);
        end

        // Clamping at and above max on-time
        duty.u = duty_width'(max_on_cycles);
        duty.v = duty_width'(max_on_cycles + 1);
        duty.w = '1;
        write_duties(duty);
        apb_write(addr_commit, 32'h1, 1'b0);
        run_check("clamped pulse widths", duty);

        // Widths change only on commit
        old_duty = duty;
        random_duty(duty, 20, 200);
        write_duties(duty);
        run_check("widths before commit", old_duty);
        run_check("widths before commit", old_duty);
        apb_write(addr_commit, 32'h1, 1'b0);
        run_check("widths after commit", duty);

        // Fault latch and recovery, with a set still pending
        apb_write(addr_commit, 32'h1, 1'b0);
        @(posedge clk);
        #2;
        fault_in = 1'b1;
        n = 0;
        @(negedge clk);
        while (phase_out !== '0 && n < fault_timeout) begin
            @(negedge clk);
            n++;
        end
        if (phase_out !== '0) begin
            timeout_errors++;
            $display("Outputs did not go low after fault_in rose");
        end
        repeat (2 * pwm_period) begin
            @(negedge clk);
            check_phase("phase_out during fault", '0, phase_out, full_mask);
        end
        apb_read_check(addr_status, 32'h1, 1'b0);
        @(posedge clk);
        #2;
        fault_in = 1'b0;
        repeat (4) @(posedge clk);
        apb_write(addr_status, 32'h1, 1'b0);
        apb_read_check(addr_status, 32'h0, 1'b0);
        repeat (3 * pwm_period) begin
            @(negedge clk);
            check_phase("phase_out before recommit", '0, phase_out, full_mask);
        end
        apb_write(addr_commit, 32'h1, 1'b0);
        run_check("widths after fault recovery", duty);

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/motor_pwm_pkg.sv
verilog/pwm_apb_regs.sv
verilog/pwm_half_period_timer.sv
verilog/pwm_three_phase_driver.sv
verilog/motor_pwm_top.sv
verif/tb_motor_pwm.sv
